/* div_params.svh */
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// ##################################################
// Divider unit sizing
// ##################################################

// Width of dividend, divisor, quotient and remainder.
`define DIV_WIDTH 16

// Width of the request tag carried to the response.
`define DIV_TAG_WIDTH 4

// Request queue entries. The sender starts with this many credits.
`define DIV_REQ_DEPTH 4

// Response credits granted by the consumer after reset.
`define DIV_RSP_CREDITS 4

`endif

/* div_pkg.sv */
`include "div_params.svh"

package div_pkg;

    // ##################################################
    // Datapath types
    // ##################################################

    typedef logic [`DIV_WIDTH-1:0] operand_t;      // Dividend, divisor, quotient, remainder.
    typedef logic [`DIV_TAG_WIDTH-1:0] tag_t;      // Request identifier.

    // Counts 0..DIV_WIDTH. Also holds queue fill and credit counts.
    typedef logic [$clog2(`DIV_WIDTH + 1)-1:0] count_t;

    // ##################################################
    // Core FSM
    // ##################################################

    typedef enum logic [1:0] {
        CORE_IDLE,                                 // Waiting for a queue entry.
        CORE_RUN,                                  // Shift-subtract steps.
        CORE_HOLD                                  // Result presented until accepted.
    } core_state_t;

endpackage

/* div_req_queue.sv */
`include "div_params.svh"

module div_req_queue (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  div_pkg::operand_t req_dividend,
    input  div_pkg::operand_t req_divisor,
    input  div_pkg::tag_t     req_tag,
    output logic             req_credit,
    output logic             q_valid,
    output div_pkg::operand_t q_dividend,
    output div_pkg::operand_t q_divisor,
    output div_pkg::tag_t     q_tag,
    input  logic             q_pop
);

    localparam int PTR_W = (`DIV_REQ_DEPTH > 1) ? $clog2(`DIV_REQ_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`DIV_REQ_DEPTH - 1);

    div_pkg::operand_t dividend_mem [`DIV_REQ_DEPTH];
    div_pkg::operand_t divisor_mem [`DIV_REQ_DEPTH];
    div_pkg::tag_t     tag_mem [`DIV_REQ_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    div_pkg::count_t   fill;                       // Entries currently held.
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign pop = q_pop && q_valid;

    // ##################################################
    // Storage
    // ##################################################

    // Sender credits guarantee a free slot, so a push is never refused.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            dividend_mem[wr_ptr] <= req_dividend;
            divisor_mem[wr_ptr]  <= req_divisor;
            tag_mem[wr_ptr]      <= req_tag;
        end
    end

    assign q_valid    = (fill != '0);
    assign q_dividend = dividend_mem[rd_ptr];
    assign q_divisor  = divisor_mem[rd_ptr];
    assign q_tag      = tag_mem[rd_ptr];

    // ##################################################
    // Pointers, fill count and credit return
    // ##################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({req_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;             // Idle, or push and pop together.
            endcase
            req_credit <= pop;                     // One credit per freed entry.
        end
    end

endmodule

/* div_core.sv */
`include "div_params.svh"

module div_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              q_valid,
    input  div_pkg::operand_t q_dividend,
    input  div_pkg::operand_t q_divisor,
    input  div_pkg::tag_t     q_tag,
    output logic              q_pop,
    output logic              res_valid,
    input  logic              res_ready,
    output div_pkg::operand_t res_quotient,
    output div_pkg::operand_t res_remainder,
    output div_pkg::tag_t     res_tag
);

    localparam int W = `DIV_WIDTH;

    div_pkg::core_state_t state;
    div_pkg::count_t      steps_left;              // Shift-subtract steps still to run.

    // Upper half is the partial remainder, lower half shifts the dividend
    // out and the quotient bits in.
    logic [2*W-1:0]       pr;
    div_pkg::operand_t    divisor_r;
    div_pkg::tag_t        tag_r;

    logic [W:0]           partial;                 // Shifted remainder with its carry bit.
    logic [W:0]           diff;
    logic                 take;
    logic [2*W-1:0]       step_pr;

    // ##################################################
    // One restoring step
    // ##################################################

    // The shifted remainder can need W+1 bits when the divisor is large,
    // so the compare keeps the bit that falls out of the upper half.
    always_comb begin
        partial = pr[2*W-1:W-1];
        diff    = partial - {1'b0, divisor_r};
        take    = (partial >= {1'b0, divisor_r});
        if (take) begin
            step_pr = {diff[W-1:0], pr[W-2:0], 1'b1};
        end else begin
            step_pr = {partial[W-1:0], pr[W-2:0], 1'b0};
        end
    end

    // A zero divisor always subtracts nothing, giving an all-ones quotient
    // and the dividend as remainder.

    // ##################################################
    // Control FSM
    // ##################################################

    assign q_pop     = (state == div_pkg::CORE_IDLE) && q_valid;
    assign res_valid = (state == div_pkg::CORE_HOLD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= div_pkg::CORE_IDLE;
            steps_left <= '0;
        end else begin
            case (state)
                div_pkg::CORE_IDLE: begin
                    if (q_valid) begin
                        steps_left <= div_pkg::count_t'(W);
                        state      <= div_pkg::CORE_RUN;
                    end
                end
                div_pkg::CORE_RUN: begin
                    steps_left <= steps_left - 1'b1;
                    if (steps_left == div_pkg::count_t'(1)) begin
                        state <= div_pkg::CORE_HOLD;   // Last step lands this edge.
                    end
                end
                div_pkg::CORE_HOLD: begin
                    if (res_ready) begin
                        state <= div_pkg::CORE_IDLE;
                    end
                end
                default: begin
                    state <= div_pkg::CORE_IDLE;
                end
            endcase
        end
    end

    // ##################################################
    // Datapath registers
    // ##################################################

    always_ff @(posedge clk) begin
        if (q_pop) begin
            pr        <= {{W{1'b0}}, q_dividend};
            divisor_r <= q_divisor;
            tag_r     <= q_tag;
        end else if (state == div_pkg::CORE_RUN) begin
            pr <= step_pr;
        end
    end

    // Registers stay frozen in hold, so the result is stable until taken.
    assign res_quotient  = pr[W-1:0];
    assign res_remainder = pr[2*W-1:W];
    assign res_tag       = tag_r;

endmodule

/* div_rsp_port.sv */
`include "div_params.svh"

module div_rsp_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              res_valid,
    output logic              res_ready,
    input  div_pkg::operand_t res_quotient,
    input  div_pkg::operand_t res_remainder,
    input  div_pkg::tag_t     res_tag,
    output logic              rsp_valid,
    output div_pkg::operand_t rsp_quotient,
    output div_pkg::operand_t rsp_remainder,
    output div_pkg::tag_t     rsp_tag,
    input  logic              rsp_credit
);

    div_pkg::count_t credits;                      // Consumer slots still free.
    logic            send;

    assign res_ready = (credits != '0);
    assign send      = res_valid && res_ready;

    // ##################################################
    // Credit counter
    // ##################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= div_pkg::count_t'(`DIV_RSP_CREDITS);
        end else begin
            case ({rsp_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;       // Return and spend cancel out.
            endcase
        end
    end

    // ##################################################
    // Response register
    // ##################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= send;                     // One pulse per result.
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            rsp_quotient  <= res_quotient;
            rsp_remainder <= res_remainder;
            rsp_tag       <= res_tag;
        end
    end

endmodule

/* div_unit_top.sv */
module div_unit_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  div_pkg::operand_t req_dividend,
    input  div_pkg::operand_t req_divisor,
    input  div_pkg::tag_t     req_tag,
    output logic              req_credit,
    output logic              rsp_valid,
    output div_pkg::operand_t rsp_quotient,
    output div_pkg::operand_t rsp_remainder,
    output div_pkg::tag_t     rsp_tag,
    input  logic              rsp_credit
);

    // Queue head to core.
    logic              q_valid;
    logic              q_pop;
    div_pkg::operand_t q_dividend;
    div_pkg::operand_t q_divisor;
    div_pkg::tag_t     q_tag;

    // Core result to response port.
    logic              res_valid;
    logic              res_ready;
    div_pkg::operand_t res_quotient;
    div_pkg::operand_t res_remainder;
    div_pkg::tag_t     res_tag;

    div_req_queue u_queue (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_dividend (req_dividend),
        .req_divisor  (req_divisor),
        .req_tag      (req_tag),
        .req_credit   (req_credit),
        .q_valid      (q_valid),
        .q_dividend   (q_dividend),
        .q_divisor    (q_divisor),
        .q_tag        (q_tag),
        .q_pop        (q_pop)
    );

    div_core u_core (
        .clk           (clk),
        .rst           (rst),
        .q_valid       (q_valid),
        .q_dividend    (q_dividend),
        .q_divisor     (q_divisor),
        .q_tag         (q_tag),
        .q_pop         (q_pop),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_quotient  (res_quotient),
        .res_remainder (res_remainder),
        .res_tag       (res_tag)
    );

    div_rsp_port u_rsp (
        .clk           (clk),
        .rst           (rst),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_quotient  (res_quotient),
        .res_remainder (res_remainder),
        .res_tag       (res_tag),
        .rsp_valid     (rsp_valid),
        .rsp_quotient  (rsp_quotient),
        .rsp_remainder (rsp_remainder),
        .rsp_tag       (rsp_tag),
        .rsp_credit    (rsp_credit)
    );

endmodule

/* div_unit_assertions.sv */
`include "div_params.svh"

module div_unit_assertions (
    input logic              clk,
    input logic              rst,
    input logic              req_valid,
    input logic              req_credit,
    input logic              rsp_valid,
    input logic              rsp_credit,
    input logic              res_valid,
    input logic              res_ready,
    input div_pkg::operand_t res_quotient,
    input div_pkg::operand_t res_remainder,
    input div_pkg::tag_t     res_tag
);

    int req_outstanding;                                 // Request credits spent, not returned.
    int rsp_available;                                   // Response credits the port may use.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_outstanding <= 0;
            rsp_available   <= `DIV_RSP_CREDITS;
        end else begin
            req_outstanding <= req_outstanding + int'(req_valid) - int'(req_credit);
            rsp_available   <= rsp_available - int'(rsp_valid) + int'(rsp_credit);
        end
    end

    // ##################################################
    // Credit and handshake rules
    // ##################################################

    credit_return_bounded: assert property (@(posedge clk) disable iff (rst)
        req_credit |-> req_outstanding > 0)
        else $error("request credit returned with none outstanding");

    rsp_needs_credit: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> rsp_available > 0)
        else $error("rsp_valid raised with no response credit left");

    res_held_stable: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_quotient)
            && $stable(res_remainder) && $stable(res_tag))
        else $error("core result changed while waiting for res_ready");

endmodule

bind div_unit_top div_unit_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_credit    (req_credit),
    .rsp_valid     (rsp_valid),
    .rsp_credit    (rsp_credit),
    .res_valid     (res_valid),
    .res_ready     (res_ready),
    .res_quotient  (res_quotient),
    .res_remainder (res_remainder),
    .res_tag       (res_tag)
);

/* div_unit_tb.sv */
`include "div_params.svh"

module div_unit_tb;

    localparam int W          = `DIV_WIDTH;
    localparam int TIMEOUT    = 2000;                    // Cycles allowed for any one wait.
    localparam int LATENCY    = `DIV_WIDTH + 3;          // req_valid to rsp_valid, idle unit.
    localparam int STALL_REQS = `DIV_RSP_CREDITS + 1 + `DIV_REQ_DEPTH;

    logic              clk;
    logic              rst;
    logic              req_valid;
    div_pkg::operand_t req_dividend;
    div_pkg::operand_t req_divisor;
    div_pkg::tag_t     req_tag;
    logic              req_credit;
    logic              rsp_valid;
    div_pkg::operand_t rsp_quotient;
    div_pkg::operand_t rsp_remainder;
    div_pkg::tag_t     rsp_tag;
    logic              rsp_credit;

    int                cycle_cnt;
    int                req_sent;                         // Requests issued by the sender.
    int                last_req_cycle;
    int                credits_back;                     // req_credit pulses seen.
    int                rsp_seen;                         // Responses checked so far.
    int                last_rsp_cycle;
    int                credits_returned;                 // rsp_credit pulses driven.
    logic              withhold;                         // Consumer keeps its credits.
    logic [31:0]       stim_lfsr;
    logic [31:0]       credit_lfsr;
    logic [2*W-1:0]    exp_pair;

    // Expected results in request order.
    logic [2*W-1:0]    exp_results[$];                   // {quotient, remainder}.
    div_pkg::tag_t     exp_tags[$];
    string             exp_names[$];

    div_unit_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_dividend  (req_dividend),
        .req_divisor   (req_divisor),
        .req_tag       (req_tag),
        .req_credit    (req_credit),
        .rsp_valid     (rsp_valid),
        .rsp_quotient  (rsp_quotient),
        .rsp_remainder (rsp_remainder),
        .rsp_tag       (rsp_tag),
        .rsp_credit    (rsp_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ##################################################
    // Helpers
    // ##################################################

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Integer division. A zero divisor gives all ones and the dividend back.
    function automatic logic [2*W-1:0] ref_divide(input div_pkg::operand_t dividend,
                                                  input div_pkg::operand_t divisor);
        if (divisor == '0) begin
            return {{W{1'b1}}, dividend};
        end
        return {dividend / divisor, dividend % divisor};
    endfunction

    function automatic int req_credits();
        return `DIV_REQ_DEPTH - req_sent + credits_back;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected=%0h actual=%0h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            bits      = {bits[30:0], stim_lfsr[0]};
        end
    endtask

    task automatic send_request(input div_pkg::operand_t dividend,
                                input div_pkg::operand_t divisor, input string name);
        int n;
        for (n = 0; n < TIMEOUT && req_credits() == 0; n++)
            tick();
        if (req_credits() == 0) begin
            fail_run({"No request credit came back during ", name, "."});
        end
        exp_results.push_back(ref_divide(dividend, divisor));
        exp_tags.push_back(div_pkg::tag_t'(req_sent));
        exp_names.push_back(name);
        req_valid      = 1'b1;
        req_dividend   = dividend;
        req_divisor    = divisor;
        req_tag        = div_pkg::tag_t'(req_sent);
        last_req_cycle = cycle_cnt;
        req_sent++;
        tick();
        req_valid = 1'b0;
    endtask

    // Divisor shifted by a random amount to spread its size.
    task automatic send_random(input string name);
        logic [31:0]       bits;
        div_pkg::operand_t a;
        div_pkg::operand_t b;
        take_bits(W, bits);
        a = bits[W-1:0];
        take_bits(W, bits);
        b = bits[W-1:0];
        take_bits(4, bits);
        b = b >> bits[3:0];
        if (b == '0) begin
            b = 1;
        end
        send_request(a, b, name);
    endtask

    task automatic wait_drained(input string name);
        int n;
        for (n = 0; n < TIMEOUT && rsp_seen != req_sent; n++)
            tick();
        if (rsp_seen != req_sent) begin
            fail_run({"Responses still missing at the end of ", name, "."});
        end
    endtask

    task automatic wait_credits_home();
        int n;
        for (n = 0; n < TIMEOUT && credits_returned != rsp_seen; n++)
            tick();
        if (credits_returned != rsp_seen) begin
            fail_run("Consumer never returned all response credits.");
        end
        tick();                                          // Let the port count the last one.
        tick();
    endtask

    // ##################################################
    // Consumer and response checking
    // ##################################################

    initial begin
        rsp_credit  = 1'b0;
        credit_lfsr = 32'h7097;
        forever begin
            @(posedge clk);
            #1;
            credit_lfsr = lfsr_next(credit_lfsr);
            if (!rst && !withhold && credits_returned < rsp_seen && credit_lfsr[0]) begin
                rsp_credit = 1'b1;
                credits_returned++;
            end else begin
                rsp_credit = 1'b0;
            end
        end
    end

    // Outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (req_credit) begin
                credits_back++;
            end
            if (req_credits() > `DIV_REQ_DEPTH) begin
                fail_run("More request credits came back than were spent.");
            end
            if (rsp_valid) begin
                if (rsp_seen >= exp_results.size()) begin
                    fail_run("A response arrived with no request outstanding.");
                end else begin
                    exp_pair = exp_results[rsp_seen];
                    check_value({exp_names[rsp_seen], " quotient"},
                                32'(exp_pair[2*W-1:W]), 32'(rsp_quotient));
                    check_value({exp_names[rsp_seen], " remainder"},
                                32'(exp_pair[W-1:0]), 32'(rsp_remainder));
                    check_value({exp_names[rsp_seen], " tag"},
                                32'(exp_tags[rsp_seen]), 32'(rsp_tag));
                    last_rsp_cycle = cycle_cnt;
                    rsp_seen++;
                end
            end
        end
    end

    // ##################################################
    // Test sequence
    // ##################################################

    initial begin
        int          base;
        logic [31:0] bits;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_dividend = '0;
        req_divisor  = '0;
        req_tag      = '0;
        withhold     = 1'b0;
        stim_lfsr    = 32'h7097;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();

        // Single request into an idle unit.
        send_request(16'd1000, 16'd7, "latency");
        wait_drained("latency");
        check_value("latency cycles", 32'(LATENCY), 32'(last_rsp_cycle - last_req_cycle));

        for (int i = 0; i < 40; i++) begin
            send_random("random");
        end
        wait_drained("random");

        take_bits(W, bits);
        send_request(bits[W-1:0], '0, "zero_divisor");
        send_request('0, '0, "zero_divisor");
        send_request('1, '0, "zero_divisor");
        wait_drained("zero_divisor");

        send_request('0, 16'd5, "edge");
        send_request('0, '1, "edge");
        send_request(16'h1234, 16'd1, "edge");
        send_request('1, 16'd1, "edge");
        send_request(16'd5, 16'd9, "edge");
        send_request(16'h00ff, 16'hff00, "edge");
        send_request('1, '1, "edge");
        send_request(16'hfffe, '1, "edge");
        send_request(16'h8000, 16'h8001, "edge");
        wait_drained("edge");

        // Spend every request credit in consecutive cycles.
        wait_credits_home();
        check_value("back_to_back start credits", `DIV_REQ_DEPTH, 32'(req_credits()));
        for (int i = 0; i < `DIV_REQ_DEPTH; i++) begin
            send_random("back_to_back");
        end
        wait_drained("back_to_back");
        check_value("back_to_back credits", `DIV_REQ_DEPTH, 32'(req_credits()));

        // The consumer stops returning credits and the unit backs up to the sender.
        wait_credits_home();
        withhold = 1'b1;
        base     = rsp_seen;
        for (int i = 0; i < STALL_REQS; i++) begin
            send_random("credit_stall");
        end
        repeat (2 * (W + 4)) tick();
        check_value("credit_stall responses", 32'(base + `DIV_RSP_CREDITS), 32'(rsp_seen));
        check_value("credit_stall request credits", 32'(0), 32'(req_credits()));
        withhold = 1'b0;
        wait_drained("credit_stall");
        check_value("credit_stall final credits", `DIV_REQ_DEPTH, 32'(req_credits()));

        wait_credits_home();
        if (rsp_seen == req_sent && req_credits() == `DIV_REQ_DEPTH) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

/* all.f */
+incdir+.
div_pkg.sv
div_req_queue.sv
div_core.sv
div_rsp_port.sv
div_unit_top.sv
div_unit_assertions.sv
div_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the divider testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module div_unit_tb -f all.f -o div_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/div_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
